/* Makefile */
SRCS := $(wildcard src/*.sv tb/*.sv)

.PHONY: run clean

run: obj_dir/VpixelReadoutTb
	obj_dir/VpixelReadoutTb > sim.log 2>&1; cat sim.log
	@if grep -q "Something failed" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Everything OK" sim.log; then echo "simulation did not finish"; exit 1; fi

obj_dir/VpixelReadoutTb: tb.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module pixelReadoutTb \
		-f tb.f -Mdir obj_dir

clean:
	rm -rf obj_dir sim.log

/* src/circularBuffer.sv */
`timescale 1ns/1ns
`default_nettype none

module circularBuffer import pixelReadoutPkg::*; #(
    parameter int cbAddrWidth = 9
) (
    input  logic        clk,
    input  logic        reset,
    input  pixelConfigT cfg,
    input  tdcWordT     selWord,
    input  logic        l1a,
    output hitRecordT   trigRecord,
    output logic        trigValid
);

    localparam int depth = 2 ** cbAddrWidth;

    hitRecordT recMem [depth];  // payload
    logic      hitMem [depth];  // hit flags, kept apart for the sweep

    logic [cbAddrWidth-1:0] wrPtr;
    logic [cbAddrWidth-1:0] rdAddr;
    logic                   sweeping;  // first pass after reset
    hitRecordT              wrRecord;

    assign wrRecord = {selWord.toa, selWord.tot, selWord.cal};

    ////////////////////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wrPtr    <= '0;
            sweeping <= 1'b1;
        end
        else
        begin
            wrPtr <= wrPtr + 1'b1;  // free running, wraps
            if (wrPtr == '1)
            begin
                sweeping <= 1'b0;  // every flag cleared once
            end
        end
    end

    always_ff @(posedge clk)
    begin
        recMem[wrPtr] <= wrRecord;
        hitMem[wrPtr] <= selWord.hit & ~sweeping;  // sweep clears old flags
    end

    ////////////////////////////////////////////////////////////////////////////
    // L1A look-back
    ////////////////////////////////////////////////////////////////////////////

    // selWord is one cycle behind tdcData, hence the +1
    assign rdAddr = wrPtr - cbAddrWidth'(cfg.latency) + cbAddrWidth'(1);

    always_ff @(posedge clk)
    begin
        if (l1a)
        begin
            trigRecord <= recMem[rdAddr];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            trigValid <= 1'b0;
        end
        else
        begin
            trigValid <= l1a & hitMem[rdAddr] & ~sweeping;  // one cycle strobe
        end
    end

endmodule

`default_nettype wire

/* src/hitSelector.sv */
`timescale 1ns/1ns
`default_nettype none

module hitSelector import pixelReadoutPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  pixelConfigT cfg,
    input  tdcWordT     tdcData,
    input  tdcWordT     testWord,
    output tdcWordT     selWord
);

    tdcWordT inUse;
    logic    useTest;
    logic    toaOk;
    logic    totOk;
    logic    calOk;

    assign useTest = (cfg.workMode == 2'd1) || (cfg.workMode == 2'd2);  // modes 0, 3 real
    assign inUse   = useTest ? testWord : tdcData;

    // inclusive windows
    assign toaOk = (inUse.toa >= cfg.toaWin.lower) && (inUse.toa <= cfg.toaWin.upper);
    assign totOk = (inUse.tot >= cfg.totWin.lower[8:0]) &&
                   (inUse.tot <= cfg.totWin.upper[8:0]);  // 9 bit tot
    assign calOk = (inUse.cal >= cfg.calWin.lower) && (inUse.cal <= cfg.calWin.upper);

    always_ff @(posedge clk)
    begin
        selWord.toa <= inUse.toa;
        selWord.tot <= inUse.tot;
        selWord.cal <= inUse.cal;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            selWord.hit <= 1'b0;
        end
        else
        begin
            selWord.hit <= inUse.hit & toaOk & totOk & calOk;  // rejected hits just lose flag
        end
    end

endmodule

`default_nettype wire

/* src/l1EventBuffer.sv */
`timescale 1ns/1ns
`default_nettype none

module l1EventBuffer import pixelReadoutPkg::*; #(
    parameter int l1AddrWidth = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  hitRecordT            trigRecord,
    input  logic                 trigValid,
    input  logic                 pop,
    output hitRecordT            headRecord,
    output logic                 empty,
    output logic [l1AddrWidth:0] count,
    output logic [7:0]           overflowCount,
    output logic                 unreadHit
);

    localparam int depth = 2 ** l1AddrWidth;

    hitRecordT mem [depth];

    // extra msb tells full from empty
    logic [l1AddrWidth:0] wrPtr;
    logic [l1AddrWidth:0] rdPtr;
    logic [l1AddrWidth:0] wrNext;
    logic [l1AddrWidth:0] rdNext;
    logic                 full;
    logic                 push;
    logic                 doPop;

    assign empty = (wrPtr == rdPtr);
    assign full  = (wrPtr[l1AddrWidth] != rdPtr[l1AddrWidth]) &&
                   (wrPtr[l1AddrWidth-1:0] == rdPtr[l1AddrWidth-1:0]);
    assign count = wrPtr - rdPtr;

    assign push  = trigValid & ~full;  // full drops the hit
    assign doPop = pop & ~empty;

    assign wrNext = wrPtr + {{l1AddrWidth{1'b0}}, push};
    assign rdNext = rdPtr + {{l1AddrWidth{1'b0}}, doPop};

    assign headRecord = mem[rdPtr[l1AddrWidth-1:0]];  // show-ahead

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wrPtr[l1AddrWidth-1:0]] <= trigRecord;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // pointers and status
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wrPtr         <= '0;
            rdPtr         <= '0;
            overflowCount <= '0;
            unreadHit     <= 1'b0;
        end
        else
        begin
            wrPtr     <= wrNext;
            rdPtr     <= rdNext;
            unreadHit <= (wrNext != rdNext);  // tracks ~empty without lag
            if (trigValid && full && (overflowCount != 8'hff))
            begin
                overflowCount <= overflowCount + 8'd1;  // saturates
            end
        end
    end

endmodule

`default_nettype wire

/* src/pixelReadoutPkg.sv */
`default_nettype none

package pixelReadoutPkg;

    ////////////////////////////////////////////////////////////////////////////
    // data words
    ////////////////////////////////////////////////////////////////////////////

    // one TDC word, same bit order as the TDC output bus
    typedef struct packed {
        logic [9:0] toa;    // time of arrival
        logic [8:0] tot;    // time over threshold
        logic [9:0] cal;    // calibration code
        logic       hit;
    } tdcWordT;

    // stored hit, flag dropped
    typedef struct packed {
        logic [9:0] toa;
        logic [8:0] tot;
        logic [9:0] cal;
    } hitRecordT;

    // inclusive bounds, tot window only looks at bits 8:0
    typedef struct packed {
        logic [9:0] lower;
        logic [9:0] upper;
    } windowT;

    typedef struct packed {
        logic [1:0] workMode;   // 0 normal, 1 fixed test, 2 random test, 3 normal
        logic [6:0] occupancy;  // random mode hit threshold
        windowT     toaWin;
        windowT     totWin;
        windowT     calWin;
        logic [8:0] latency;    // L1A look-back in cycles
    } pixelConfigT;

    ////////////////////////////////////////////////////////////////////////////
    // register map, word addresses
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [2:0] regCtrl    = 3'd0;
    localparam logic [2:0] regToaWin  = 3'd1;
    localparam logic [2:0] regTotWin  = 3'd2;
    localparam logic [2:0] regCalWin  = 3'd3;
    localparam logic [2:0] regLatency = 3'd4;
    localparam logic [2:0] regStatus  = 3'd5;  // read only
    localparam logic [2:0] regData    = 3'd6;  // read only, pops

    // reset values
    localparam logic [1:0] defWorkMode  = 2'd0;
    localparam logic [6:0] defOccupancy = 7'd0;
    localparam windowT     defWindow    = '{lower: 10'h000, upper: 10'h3ff};  // fully open
    localparam logic [8:0] defLatency   = 9'd100;

endpackage

`default_nettype wire

/* src/pixelReadoutTop.sv */
`timescale 1ns/1ns
`default_nettype none

module pixelReadoutTop import pixelReadoutPkg::*; #(
    parameter int cbAddrWidth = 9,  // 512 deep latency memory
    parameter int l1AddrWidth = 4   // 16 deep event buffer
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  pixelId,  // strap
    input  tdcWordT     tdcData,
    input  logic        l1a,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [2:0]  adr,
    input  logic [31:0] datW,
    output logic [31:0] datR,
    output logic        ack,
    output logic        unreadHit
);

    pixelConfigT          cfg;
    tdcWordT              testWord;
    tdcWordT              selWord;
    hitRecordT            trigRecord;
    logic                 trigValid;
    hitRecordT            headRecord;
    logic                 empty;
    logic [l1AddrWidth:0] count;
    logic [7:0]           overflowCount;
    logic                 pop;

    pixelRegisterBus #(.l1AddrWidth(l1AddrWidth)) regBus (
        .clk(clk), .reset(reset),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datW(datW), .datR(datR), .ack(ack),
        .cfg(cfg),
        .headRecord(headRecord), .empty(empty), .count(count),
        .overflowCount(overflowCount), .pop(pop)
    );

    // input side
    tdcPatternGen patternGen (
        .clk(clk), .reset(reset), .cfg(cfg), .pixelId(pixelId), .testWord(testWord)
    );

    hitSelector selector (
        .clk(clk), .reset(reset), .cfg(cfg),
        .tdcData(tdcData), .testWord(testWord), .selWord(selWord)
    );

    circularBuffer #(.cbAddrWidth(cbAddrWidth)) latencyBuf (
        .clk(clk), .reset(reset), .cfg(cfg), .selWord(selWord), .l1a(l1a),
        .trigRecord(trigRecord), .trigValid(trigValid)
    );

    l1EventBuffer #(.l1AddrWidth(l1AddrWidth)) eventBuf (
        .clk(clk), .reset(reset),
        .trigRecord(trigRecord), .trigValid(trigValid), .pop(pop),
        .headRecord(headRecord), .empty(empty), .count(count),
        .overflowCount(overflowCount), .unreadHit(unreadHit)
    );

endmodule

`default_nettype wire

/* src/pixelRegisterBus.sv */
`timescale 1ns/1ns
`default_nettype none

module pixelRegisterBus import pixelReadoutPkg::*; #(
    parameter int l1AddrWidth = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  logic [2:0]           adr,
    input  logic [31:0]          datW,
    output logic [31:0]          datR,
    output logic                 ack,
    output pixelConfigT          cfg,
    input  hitRecordT            headRecord,
    input  logic                 empty,
    input  logic [l1AddrWidth:0] count,
    input  logic [7:0]           overflowCount,
    output logic                 pop
);

    logic        access;    // first cycle of a transfer
    logic [31:0] readMux;

    // window register layout, lower in 9:0, upper in 25:16
    function automatic logic [31:0] winToWord(input windowT w);
        logic [31:0] word;
        word        = '0;
        word[9:0]   = w.lower;
        word[25:16] = w.upper;
        return word;
    endfunction

    function automatic windowT wordToWin(input logic [31:0] word);
        windowT w;
        w.lower = word[9:0];
        w.upper = word[25:16];
        return w;
    endfunction

    assign access = cyc & stb & ~ack;  // ack low again forces the idle cycle

    always_comb
    begin
        readMux = '0;
        case (adr)
            regCtrl:
            begin
                readMux[1:0]  = cfg.workMode;
                readMux[14:8] = cfg.occupancy;
            end
            regToaWin:  readMux = winToWord(cfg.toaWin);
            regTotWin:  readMux = winToWord(cfg.totWin);
            regCalWin:  readMux = winToWord(cfg.calWin);
            regLatency: readMux[8:0] = cfg.latency;
            regStatus:
            begin
                readMux[15:0]  = 16'(count);  // words waiting
                readMux[23:16] = overflowCount;
            end
            regData:
                if (!empty)
                begin
                    readMux = {1'b1, 2'b00, headRecord};  // bit 31 valid
                end
            default: readMux = '0;
        endcase
    end

    // handshake, one ack per transfer, no wait states
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ack <= 1'b0;
            pop <= 1'b0;
        end
        else
        begin
            ack <= access;
            pop <= access & ~we & (adr == regData) & ~empty;  // lines up with ack
        end
    end

    always_ff @(posedge clk)
    begin
        if (access)
        begin
            datR <= readMux;  // held valid through ack
        end
    end

    // config update at end of ack cycle, master still holds adr/datW
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cfg.workMode  <= defWorkMode;
            cfg.occupancy <= defOccupancy;
            cfg.toaWin    <= defWindow;
            cfg.totWin    <= defWindow;
            cfg.calWin    <= defWindow;
            cfg.latency   <= defLatency;
        end
        else if (ack && we)
        begin
            case (adr)
                regCtrl:
                begin
                    cfg.workMode  <= datW[1:0];
                    cfg.occupancy <= datW[14:8];
                end
                regToaWin:  cfg.toaWin  <= wordToWin(datW);
                regTotWin:  cfg.totWin  <= wordToWin(datW);
                regCalWin:  cfg.calWin  <= wordToWin(datW);
                regLatency: cfg.latency <= datW[8:0];
                default: ;  // status and data ignore writes
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/tdcPatternGen.sv */
`timescale 1ns/1ns
`default_nettype none

module tdcPatternGen import pixelReadoutPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  pixelConfigT cfg,
    input  logic [7:0]  pixelId,
    output tdcWordT     testWord
);

    localparam logic [29:0] lfsrSeed = 30'h1234_5678;  // any nonzero
    localparam logic [8:0]  fixedTot = 9'd100;
    localparam logic [9:0]  fixedCal = 10'd200;

    logic [29:0] lfsr;
    logic        feedback;
    logic        randomMode;

    assign randomMode = (cfg.workMode == 2'd2);

    // x^30 + x^6 + x^4 + x + 1, maximal length
    assign feedback = lfsr[29] ^ lfsr[5] ^ lfsr[3] ^ lfsr[0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lfsr <= lfsrSeed;
        end
        else if (randomMode)
        begin
            lfsr <= {lfsr[28:0], feedback};  // frozen outside random mode
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // word build
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        if (cfg.workMode == 2'd1)
        begin
            // fixed pattern, toa carries the pixel id
            testWord.toa = {2'b00, pixelId};
            testWord.tot = fixedTot;
            testWord.cal = fixedCal;
            testWord.hit = 1'b1;
        end
        else
        begin
            testWord.toa = lfsr[29:20];
            testWord.tot = lfsr[19:11];
            testWord.cal = lfsr[10:1];
            testWord.hit = (lfsr[6:0] < cfg.occupancy);  // occupancy/128 hit rate
        end
    end

endmodule

`default_nettype wire

/* tb.f */
src/pixelReadoutPkg.sv
src/pixelRegisterBus.sv
src/tdcPatternGen.sv
src/hitSelector.sv
src/circularBuffer.sv
src/l1EventBuffer.sv
src/pixelReadoutTop.sv
tb/pixelReadout_asserts.sv
tb/pixelReadoutTb.sv

/* tb/pixelReadoutTb.sv */
`timescale 1ns/1ns
`default_nettype none

module pixelReadoutTb import pixelReadoutPkg::*; ();

    // reset, sweep wait, six tests with their readout, roughly 1900 cycles
    localparam int testCycles = 2500;
    localparam int cycleLimit = 2 * testCycles;
    localparam logic [7:0] strapId = 8'h5a;

    logic        clk;
    logic        reset;
    logic [7:0]  pixelId;
    tdcWordT     tdcData;
    logic        l1a;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [2:0]  adr;
    logic [31:0] datW;
    logic [31:0] datR;
    logic        ack;
    logic        unreadHit;

    // reference model state
    tdcWordT     history [0:8191];  // selected word per cycle, hit already windowed
    hitRecordT   expQ [$];
    hitRecordT   gotQ [$];          // raw records in random mode
    int          cycleNo;
    logic        modelOn;
    logic [1:0]  modelMode;
    windowT      modelToa;
    windowT      modelTot;
    windowT      modelCal;
    logic [8:0]  modelLatency;
    int          mismatchCount;
    int          failCount;

    pixelReadoutTop #(.cbAddrWidth(9), .l1AddrWidth(4)) uut (
        .clk(clk), .reset(reset), .pixelId(pixelId), .tdcData(tdcData), .l1a(l1a),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datW(datW), .datR(datR), .ack(ack),
        .unreadHit(unreadHit)
    );

    always #2 clk = ~clk;  // 4 ns period

    ////////////////////////////////////////////////////////////////////////////
    // model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic inWindows(input hitRecordT r);
        return (r.toa >= modelToa.lower) && (r.toa <= modelToa.upper) &&
               (r.tot >= modelTot.lower[8:0]) && (r.tot <= modelTot.upper[8:0]) &&
               (r.cal >= modelCal.lower) && (r.cal <= modelCal.upper);
    endfunction

    function automatic tdcWordT modelSelect(input tdcWordT raw);
        tdcWordT w;
        w = raw;
        if (modelMode == 2'd1)
        begin
            w.toa = {2'b00, pixelId};  // fixed self-test pattern
            w.tot = 9'd100;
            w.cal = 10'd200;
            w.hit = 1'b1;
        end
        w.hit = w.hit & inWindows({w.toa, w.tot, w.cal});
        return w;
    endfunction

    // inputs change on the falling edge, so the rising edge sees them settled
    always @(posedge clk)
    begin : modelStep
        tdcWordT target;
        history[cycleNo] = modelSelect(tdcData);
        if (l1a && modelOn && (cycleNo >= int'(modelLatency)))
        begin
            target = history[cycleNo - int'(modelLatency)];
            if (target.hit)
                expQ.push_back({target.toa, target.tot, target.cal});
        end
        cycleNo++;
        if (cycleNo >= cycleLimit)
        begin
            $display("timeout: run went past %0d cycles", cycleLimit);
            $display("Something failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // drivers
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("mismatch %s: expected %h, actual %h", testName, expected, actual);
            mismatchCount++;
        end
    endtask

    task automatic driveCycle(input tdcWordT word, input logic trig);
        @(negedge clk);
        tdcData = word;
        l1a     = trig;
    endtask

    task automatic idle(input int n);
        repeat (n) driveCycle('0, 1'b0);
    endtask

    // classic handshake, master holds everything until ack
    task automatic busTransfer(input logic write, input logic [2:0] addr,
                               input logic [31:0] data, output logic [31:0] rdata);
        int waitCycles;
        waitCycles = 0;
        @(negedge clk);
        cyc  = 1'b1;
        stb  = 1'b1;
        we   = write;
        adr  = addr;
        datW = data;
        while (!ack && waitCycles < 4)
        begin
            @(negedge clk);
            waitCycles++;
        end
        rdata = datR;
        if (!ack)
        begin
            $display("no ack within 4 cycles on %s of register %0d",
                     write ? "write" : "read", addr);
            failCount++;
        end
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic wbWrite(input logic [2:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        busTransfer(1'b1, addr, data, unused);
        @(negedge clk);  // register loaded on the ack edge
    endtask

    task automatic wbRead(input logic [2:0] addr, output logic [31:0] data);
        busTransfer(1'b0, addr, '0, data);
    endtask

    task automatic setMode(input logic [1:0] mode, input logic [6:0] occ);
        wbWrite(regCtrl, {17'b0, occ, 6'b0, mode});
        modelMode = mode;
    endtask

    task automatic setLatency(input logic [8:0] lat);
        wbWrite(regLatency, {23'b0, lat});
        modelLatency = lat;
    endtask

    task automatic setWindows(input windowT toaW, input windowT totW, input windowT calW);
        wbWrite(regToaWin, {6'b0, toaW.upper, 6'b0, toaW.lower});
        wbWrite(regTotWin, {6'b0, totW.upper, 6'b0, totW.lower});
        wbWrite(regCalWin, {6'b0, calW.upper, 6'b0, calW.lower});
        modelToa = toaW;
        modelTot = totW;
        modelCal = calW;
    endtask

    task automatic triggerTrain(input int count, input int spacing);
        for (int i = 0; i < count; i++)
        begin
            driveCycle('0, 1'b1);
            idle(spacing - 1);
        end
        idle(4);  // last record lands in the event buffer
    endtask

    // read until the model queue is used up, then one read must be empty
    task automatic checkReadout(input string testName, output int validReads);
        logic [31:0] word;
        hitRecordT   expRec;
        validReads = 0;
        idle(4);
        while (expQ.size() > 0)
        begin
            expRec = expQ.pop_front();
            wbRead(regData, word);
            if (word[31])
                validReads++;
            checkValue(testName, {1'b1, 2'b00, expRec}, word);
        end
        wbRead(regData, word);
        checkValue(testName, 32'h0000_0000, word);
    endtask

    task automatic collectRecords();
        logic [31:0] word;
        gotQ.delete();
        for (int i = 0; i < 20; i++)  // more than the buffer holds
        begin
            wbRead(regData, word);
            if (!word[31])
                break;
            gotQ.push_back(word[28:0]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic testRegisters();
        logic [31:0] word;
        wbRead(regCtrl, word);
        checkValue("regDefaults", 32'h0000_0000, word);
        wbRead(regToaWin, word);
        checkValue("regDefaults", 32'h03ff_0000, word);  // open window
        wbRead(regTotWin, word);
        checkValue("regDefaults", 32'h03ff_0000, word);
        wbRead(regCalWin, word);
        checkValue("regDefaults", 32'h03ff_0000, word);
        wbRead(regLatency, word);
        checkValue("regDefaults", 32'd100, word);
        wbRead(regStatus, word);
        checkValue("regDefaults", 32'h0000_0000, word);
        // mode 3 counts as normal, so nothing random reaches the memory
        wbWrite(regCtrl, 32'h0000_2a03);
        wbRead(regCtrl, word);
        checkValue("regAccess", 32'h0000_2a03, word);
        wbWrite(regToaWin, 32'h0123_0045);
        wbRead(regToaWin, word);
        checkValue("regAccess", 32'h0123_0045, word);
        wbWrite(regTotWin, 32'h01f0_0011);
        wbRead(regTotWin, word);
        checkValue("regAccess", 32'h01f0_0011, word);
        wbWrite(regCalWin, 32'h0300_0100);
        wbRead(regCalWin, word);
        checkValue("regAccess", 32'h0300_0100, word);
        wbWrite(regLatency, 32'h0000_0155);
        wbRead(regLatency, word);
        checkValue("regAccess", 32'h0000_0155, word);
        wbWrite(regStatus, 32'hffff_ffff);  // read only
        wbRead(regStatus, word);
        checkValue("regAccess", 32'h0000_0000, word);
        setMode(2'd0, 7'd0);
        setWindows(defWindow, defWindow, defWindow);
        setLatency(defLatency);
    endtask

    task automatic runLookBack(input int cycles, input int trigStart, input int trigRate);
        tdcWordT     word;
        logic [31:0] rnd;
        logic        trig;
        int          trigs;
        trigs = 0;
        for (int i = 0; i < cycles; i++)
        begin
            rnd      = $urandom;
            word     = rnd[29:0];
            word.hit = ($urandom % 4) == 0;  // sparse hits
            trig     = (i >= trigStart) && (trigs < 12) && (($urandom % trigRate) == 0);
            if (trig)
                trigs++;  // at most 12 stored, no overflow
            driveCycle(word, trig);
        end
        driveCycle('0, 1'b0);
    endtask

    task automatic testLookBack();
        int n;
        setLatency(9'd10);
        runLookBack(150, 10, 8);
        checkReadout("lookBack10", n);
        setLatency(9'd300);
        runLookBack(420, 300, 8);
        checkReadout("lookBack300", n);
    endtask

    task automatic testWindows();
        int      toaVals [5] = '{99, 100, 150, 200, 201};
        int      totVals [5] = '{49, 50, 55, 60, 61};
        int      calVals [5] = '{299, 300, 350, 400, 401};
        tdcWordT probes [15];
        tdcWordT word;
        int      n;
        for (int k = 0; k < 5; k++)
        begin
            probes[k]      = '{toa: 10'd150, tot: 9'd55, cal: 10'd350, hit: 1'b1};
            probes[k].toa  = 10'(toaVals[k]);
            probes[k + 5]  = '{toa: 10'd150, tot: 9'd55, cal: 10'd350, hit: 1'b1};
            probes[k + 5].tot = 9'(totVals[k]);
            probes[k + 10] = '{toa: 10'd150, tot: 9'd55, cal: 10'd350, hit: 1'b1};
            probes[k + 10].cal = 10'(calVals[k]);
        end
        setWindows('{lower: 10'd100, upper: 10'd200}, '{lower: 10'd50, upper: 10'd60},
                   '{lower: 10'd300, upper: 10'd400});
        setLatency(9'd10);
        // probe on even cycles, trigger each one 10 cycles later
        for (int i = 0; i < 40; i++)
        begin
            word = '0;
            if (i < 30 && (i % 2) == 0)
                word = probes[i / 2];
            driveCycle(word, (i >= 10) && ((i - 10) % 2 == 0));
        end
        driveCycle('0, 1'b0);
        checkReadout("windows", n);
        if (n != 9)
        begin
            $display("windows stored %0d hits, 9 lie inside the bounds", n);
            failCount++;
        end
        setWindows(defWindow, defWindow, defWindow);
    endtask

    task automatic testFixedMode();
        tdcWordT     word;
        logic [31:0] rnd;
        int          n;
        setMode(2'd1, 7'd0);
        idle(15);  // past the look-back
        for (int i = 0; i < 40; i++)
        begin
            rnd  = $urandom;
            word = rnd[29:0];  // ignored in fixed mode
            driveCycle(word, (i % 5) == 0);
        end
        driveCycle('0, 1'b0);
        setMode(2'd0, 7'd0);
        checkReadout("fixedMode", n);
        if (n != 8)
        begin
            $display("fixed mode stored %0d records instead of 8", n);
            failCount++;
        end
    endtask

    task automatic testOverflow();
        tdcWordT     word;
        logic [31:0] rnd;
        logic [31:0] rdWord;
        hitRecordT   expRec;
        setLatency(9'd20);
        idle(4);
        // 20 hits back to back, then 20 triggers onto them
        for (int i = 0; i < 40; i++)
        begin
            rnd      = $urandom;
            word     = rnd[29:0];
            word.hit = (i < 20);
            driveCycle(word, i >= 20);
        end
        idle(4);
        if (!unreadHit)
        begin
            $display("unreadHit low with a full event buffer");
            failCount++;
        end
        wbRead(regStatus, rdWord);
        checkValue("overflow", 32'h0004_0010, rdWord);  // 4 dropped, 16 held
        for (int i = 0; i < 16; i++)
        begin
            expRec = expQ.pop_front();
            wbRead(regData, rdWord);
            checkValue("overflow", {1'b1, 2'b00, expRec}, rdWord);
        end
        expQ.delete();  // the dropped ones
        wbRead(regData, rdWord);
        checkValue("overflow", 32'h0000_0000, rdWord);
        idle(2);
        if (unreadHit)
        begin
            $display("unreadHit still high after draining the event buffer");
            failCount++;
        end
    endtask

    task automatic testRandomMode();
        modelOn = 1'b0;  // LFSR content not modeled
        setMode(2'd2, 7'd127);
        idle(30);
        triggerTrain(8, 3);
        collectRecords();
        if (gotQ.size() == 0)
        begin
            $display("random mode with occupancy 127 stored no hits");
            failCount++;
        end
        setWindows('{lower: 10'h100, upper: 10'h2ff}, '{lower: 10'h040, upper: 10'h1bf},
                   '{lower: 10'h100, upper: 10'h2ff});
        idle(30);  // old window decisions age out
        triggerTrain(16, 2);
        collectRecords();
        foreach (gotQ[i])
        begin
            if (!inWindows(gotQ[i]))
            begin
                $display("random mode record %h lies outside the windows", gotQ[i]);
                failCount++;
            end
        end
        setMode(2'd2, 7'd0);
        idle(30);
        triggerTrain(8, 3);
        collectRecords();
        if (gotQ.size() != 0)
        begin
            $display("random mode with occupancy 0 stored %0d hits", gotQ.size());
            failCount++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        void'($urandom(32'h3a38_2580));
        clk          = 1'b0;
        reset        = 1'b1;
        pixelId      = strapId;
        tdcData      = '0;
        l1a          = 1'b0;
        cyc          = 1'b0;
        stb          = 1'b0;
        we           = 1'b0;
        adr          = '0;
        datW         = '0;
        cycleNo      = 0;
        modelOn      = 1'b1;
        modelMode    = defWorkMode;
        modelToa     = defWindow;
        modelTot     = defWindow;
        modelCal     = defWindow;
        modelLatency = defLatency;
        mismatchCount = 0;
        failCount    = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        testRegisters();
        idle(520);  // latency memory flag sweep
        testLookBack();
        testWindows();
        testFixedMode();
        testOverflow();
        testRandomMode();
        idle(4);
        $display("summary: %0d mismatches, %0d other errors", mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/pixelReadout_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module pixelReadoutAsserts #(
    parameter int l1AddrWidth = 4
) (
    input logic                 clk,
    input logic                 reset,
    input logic                 cyc,
    input logic                 stb,
    input logic                 ack,
    input logic                 unreadHit,
    input logic [l1AddrWidth:0] count
);

    // single cycle ack, idle cycle before the next one
    ackOneCycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else $error("ack high for more than one cycle");

    // no ack without a request in the cycle before
    ackAfterStb: assert property (@(posedge clk) disable iff (reset) ack |-> $past(cyc && stb))
        else $error("ack without cyc and stb the cycle before");

    unreadMatchesCount: assert property (@(posedge clk) disable iff (reset)
        unreadHit == (count != '0))
        else $error("unreadHit disagrees with the event buffer count");

endmodule

bind pixelReadoutTop pixelReadoutAsserts #(.l1AddrWidth(l1AddrWidth)) checks (
    .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .ack(ack),
    .unreadHit(unreadHit), .count(count)
);

`default_nettype wire
